// File: hw/ttl_bus_pkg.sv
`default_nettype none

package ttl_bus_pkg;

   //////////////////////////////
   // Bus widths
   //////////////////////////////

   localparam int DATA_W = 8;     // Internal bus width
   localparam int ADDR_W = 3;     // Up to eight 574s
   localparam int OP_W   = 2;
   localparam int JK_W   = 4;     // Two flags, J and K each

   typedef logic [DATA_W-1:0] data_t;   // One bus word
   typedef logic [ADDR_W-1:0] addr_t;   // Register select
   typedef logic [OP_W-1:0]   op_t;     // Operation code

   // Flag control, top bit down: j1 k1 j2 k2
   typedef logic [JK_W-1:0]   jk_t;

   //////////////////////////////
   // Operation codes
   //////////////////////////////

   localparam op_t OP_WRITE = 2'd0;   // Store a byte
   localparam op_t OP_READ  = 2'd1;   // Fetch a byte
   localparam op_t OP_FLAG  = 2'd2;   // Clock the JK pair
   // Code 3 reserved, behaves as a read of register 0

   // Arbiter sequencing
   typedef enum logic [1:0] {
      IDLE,    // Waiting for a request
      EXEC,    // Bus strobe out
      RESP     // Response to client
   } arb_state_t;

endpackage

`default_nettype wire

// File: hw/octal_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

// Bank of 74x574 style octal registers
// Tristate /OE replaced by a registered read mux
module octal_reg_bank #(
   parameter int REG_COUNT = 4              // 1 to 8 chips
) (
   input  wire                      clk,
   input  wire                      rst,    // Active low
   input  wire                      wr_en,  // Load addressed register
   input  wire                      rd_en,  // Capture addressed register
   input  wire ttl_bus_pkg::addr_t  addr,
   input  wire ttl_bus_pkg::data_t  wdata,
   output ttl_bus_pkg::data_t       rdata
);

   ttl_bus_pkg::data_t regs [REG_COUNT];    // The 574s themselves
   ttl_bus_pkg::data_t rd_sel;              // Selected chip output

   //////////////////////////////
   // Write side
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst) begin
         for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         // Out of range address hits no chip
         for (int i = 0; i < REG_COUNT; i++) begin
            if (addr == ttl_bus_pkg::addr_t'(i)) regs[i] <= wdata;
         end
      end
   end

   //////////////////////////////
   // Read side
   //////////////////////////////

   always_comb begin
      rd_sel = '0;                          // Nothing enabled reads 0
      for (int i = 0; i < REG_COUNT; i++) begin
         if (addr == ttl_bus_pkg::addr_t'(i)) rd_sel = regs[i];
      end
   end

   // Output latch stands in for /OE
   always_ff @(posedge clk) begin
      if (rd_en) rdata <= rd_sel;
   end

endmodule

`default_nettype wire

// File: hw/jk_flag_pair.sv
`timescale 1ns/1ps
`default_nettype none

// Two 74x112 style JK flops, clocked on the rising edge
module jk_flag_pair (
   input  wire                    clk,
   input  wire                    rst,     // Active low, clears q
   input  wire                    jk_en,   // Clock enable for both flops
   input  wire ttl_bus_pkg::jk_t  jk,      // j1 k1 j2 k2
   output logic [1:0]             q,       // Bit 0 is flag 1
   output logic [1:0]             qn       // Complement, own register
);

   logic [1:0] j;
   logic [1:0] k;
   logic [1:0] q_next;

   // Unpack the control nibble
   assign j = {jk[1], jk[3]};
   assign k = {jk[0], jk[2]};

   //////////////////////////////
   // JK truth table
   //////////////////////////////

   always_comb begin
      for (int i = 0; i < 2; i++) begin
         case ({j[i], k[i]})
            2'b01:   q_next[i] = 1'b0;     // Clear
            2'b10:   q_next[i] = 1'b1;     // Set
            2'b11:   q_next[i] = ~q[i];    // Toggle
            default: q_next[i] = q[i];     // Hold
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rst) begin
         q  <= 2'b00;
         qn <= 2'b11;                      // Chip in reset: /Q high
      end else if (jk_en) begin
         q  <= q_next;
         qn <= ~q_next;
      end
   end

endmodule

`default_nettype wire

// File: hw/bus_target.sv
`timescale 1ns/1ps
`default_nettype none

// Bus decode for the register bank and the flag pair
module bus_target #(
   parameter int REG_COUNT = 4
) (
   input  wire                      clk,
   input  wire                      rst,
   input  wire                      bus_go,     // One cycle strobe
   input  wire ttl_bus_pkg::op_t    bus_op,
   input  wire ttl_bus_pkg::addr_t  bus_addr,
   input  wire ttl_bus_pkg::data_t  bus_wdata,
   output ttl_bus_pkg::data_t       bus_rdata   // Valid the cycle after bus_go
);

   logic                bank_wr;
   logic                bank_rd;
   logic                jk_en;
   ttl_bus_pkg::addr_t  bank_addr;
   ttl_bus_pkg::data_t  bank_rdata;
   ttl_bus_pkg::data_t  echo_q;       // Write response word
   ttl_bus_pkg::op_t    last_op;      // Op issued with the last strobe
   logic [1:0]          q;
   logic [1:0]          qn;

   //////////////////////////////
   // Strobe decode
   //////////////////////////////

   assign bank_wr = bus_go && (bus_op == ttl_bus_pkg::OP_WRITE);
   assign jk_en   = bus_go && (bus_op == ttl_bus_pkg::OP_FLAG);
   // Read and the reserved code both read
   assign bank_rd = bus_go && !bank_wr && !jk_en;
   // Reserved code always lands on register 0
   assign bank_addr = (bus_op == ttl_bus_pkg::OP_READ || bus_op == ttl_bus_pkg::OP_WRITE)
                      ? bus_addr : '0;

   always_ff @(posedge clk) begin
      if (!rst) last_op <= ttl_bus_pkg::OP_READ;
      else if (bus_go) last_op <= bus_op;
   end

   // Echo only what actually landed in a chip
   always_ff @(posedge clk) begin
      if (bank_wr) echo_q <= (int'(bus_addr) < REG_COUNT) ? bus_wdata : '0;
   end

   octal_reg_bank #(.REG_COUNT(REG_COUNT)) u_bank (
      .clk(clk), .rst(rst), .wr_en(bank_wr), .rd_en(bank_rd),
      .addr(bank_addr), .wdata(bus_wdata), .rdata(bank_rdata)
   );

   jk_flag_pair u_flags (
      .clk(clk), .rst(rst), .jk_en(jk_en), .jk(bus_wdata[3:0]), .q(q), .qn(qn)
   );

   // Response mux with the nibble as qn2 q2 qn1 q1
   always_comb begin
      case (last_op)
         ttl_bus_pkg::OP_WRITE: bus_rdata = echo_q;
         ttl_bus_pkg::OP_FLAG:  bus_rdata = {4'b0000, qn[1], q[1], qn[0], q[0]};
         default:               bus_rdata = bank_rdata;
      endcase
   end

endmodule

`default_nettype wire

// File: hw/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

// Round robin between two clients, one transaction in flight
module bus_arbiter (
   input  wire                      clk,
   input  wire                      rst,
   // Client A
   input  wire                      a_req_valid,
   output logic                     a_req_ready,
   input  wire ttl_bus_pkg::op_t    a_op,
   input  wire ttl_bus_pkg::addr_t  a_addr,
   input  wire ttl_bus_pkg::data_t  a_wdata,
   output logic                     a_rsp_valid,
   input  wire                      a_rsp_ready,
   output ttl_bus_pkg::data_t       a_rsp_data,
   // Client B
   input  wire                      b_req_valid,
   output logic                     b_req_ready,
   input  wire ttl_bus_pkg::op_t    b_op,
   input  wire ttl_bus_pkg::addr_t  b_addr,
   input  wire ttl_bus_pkg::data_t  b_wdata,
   output logic                     b_rsp_valid,
   input  wire                      b_rsp_ready,
   output ttl_bus_pkg::data_t       b_rsp_data,
   // Internal bus
   output logic                     bus_go,
   output ttl_bus_pkg::op_t         bus_op,
   output ttl_bus_pkg::addr_t       bus_addr,
   output ttl_bus_pkg::data_t       bus_wdata,
   input  wire ttl_bus_pkg::data_t  bus_rdata
);

   ttl_bus_pkg::arb_state_t state;
   logic                last_b;       // B won the last grant
   logic                rsp_valid;    // Response word loaded
   logic                rsp_ready;    // From the granted client
   logic                pick_a;
   logic                pick_b;
   ttl_bus_pkg::data_t  rsp_word;

   //////////////////////////////
   // Grant
   //////////////////////////////

   // On a tie the loser of last round goes
   assign pick_a = (state == ttl_bus_pkg::IDLE) && a_req_valid && (!b_req_valid || last_b);
   assign pick_b = (state == ttl_bus_pkg::IDLE) && b_req_valid && !pick_a;
   assign a_req_ready = pick_a;
   assign b_req_ready = pick_b;
   assign rsp_ready = last_b ? b_rsp_ready : a_rsp_ready;

   always_ff @(posedge clk) begin
      if (!rst) begin
         state     <= ttl_bus_pkg::IDLE;
         last_b    <= 1'b1;                 // A first after reset
         rsp_valid <= 1'b0;
      end else begin
         case (state)
            ttl_bus_pkg::IDLE: if (pick_a || pick_b) begin
               state  <= ttl_bus_pkg::EXEC;
               last_b <= pick_b;
            end
            ttl_bus_pkg::EXEC: state <= ttl_bus_pkg::RESP;
            ttl_bus_pkg::RESP: if (!rsp_valid) begin
               rsp_valid <= 1'b1;          // Target data now settled
            end else if (rsp_ready) begin
               rsp_valid <= 1'b0;
               state     <= ttl_bus_pkg::IDLE;
            end
            default: state <= ttl_bus_pkg::IDLE;
         endcase
      end
   end

   // Request and response payload
   always_ff @(posedge clk) begin
      if (pick_a) {bus_op, bus_addr, bus_wdata} <= {a_op, a_addr, a_wdata};
      if (pick_b) {bus_op, bus_addr, bus_wdata} <= {b_op, b_addr, b_wdata};
      if (state == ttl_bus_pkg::RESP && !rsp_valid) rsp_word <= bus_rdata;
   end

   assign bus_go = (state == ttl_bus_pkg::EXEC);

   // Steer to the granted side only
   assign a_rsp_valid = rsp_valid && !last_b;
   assign b_rsp_valid = rsp_valid && last_b;
   assign a_rsp_data  = a_rsp_valid ? rsp_word : '0;
   assign b_rsp_data  = b_rsp_valid ? rsp_word : '0;

endmodule

`default_nettype wire

// File: hw/ttl_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

// Two clients, one arbiter, one target
module ttl_bus_top #(
   parameter int REG_COUNT = 4              // Number of 574s, 1 to 8
) (
   input  wire                      clk,
   input  wire                      rst,
   // Client A
   input  wire                      a_req_valid,
   output logic                     a_req_ready,
   input  wire ttl_bus_pkg::op_t    a_op,
   input  wire ttl_bus_pkg::addr_t  a_addr,
   input  wire ttl_bus_pkg::data_t  a_wdata,
   output logic                     a_rsp_valid,
   input  wire                      a_rsp_ready,
   output ttl_bus_pkg::data_t       a_rsp_data,
   // Client B
   input  wire                      b_req_valid,
   output logic                     b_req_ready,
   input  wire ttl_bus_pkg::op_t    b_op,
   input  wire ttl_bus_pkg::addr_t  b_addr,
   input  wire ttl_bus_pkg::data_t  b_wdata,
   output logic                     b_rsp_valid,
   input  wire                      b_rsp_ready,
   output ttl_bus_pkg::data_t       b_rsp_data
);

   //////////////////////////////
   // Internal bus
   //////////////////////////////

   logic                bus_go;       // Strobe, EXEC only
   ttl_bus_pkg::op_t    bus_op;
   ttl_bus_pkg::addr_t  bus_addr;
   ttl_bus_pkg::data_t  bus_wdata;
   ttl_bus_pkg::data_t  bus_rdata;    // Back from the target

   bus_arbiter u_arb (
      .clk(clk), .rst(rst),
      .a_req_valid(a_req_valid), .a_req_ready(a_req_ready),
      .a_op(a_op), .a_addr(a_addr), .a_wdata(a_wdata),
      .a_rsp_valid(a_rsp_valid), .a_rsp_ready(a_rsp_ready), .a_rsp_data(a_rsp_data),
      .b_req_valid(b_req_valid), .b_req_ready(b_req_ready),
      .b_op(b_op), .b_addr(b_addr), .b_wdata(b_wdata),
      .b_rsp_valid(b_rsp_valid), .b_rsp_ready(b_rsp_ready), .b_rsp_data(b_rsp_data),
      .bus_go(bus_go), .bus_op(bus_op), .bus_addr(bus_addr),
      .bus_wdata(bus_wdata), .bus_rdata(bus_rdata)
   );

   // Bank and flags behind the bus
   bus_target #(.REG_COUNT(REG_COUNT)) u_target (
      .clk(clk), .rst(rst),
      .bus_go(bus_go), .bus_op(bus_op), .bus_addr(bus_addr),
      .bus_wdata(bus_wdata), .bus_rdata(bus_rdata)
   );

endmodule

`default_nettype wire

// File: bench/ttl_bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ttl_bus_tb;

   localparam int WAIT_LIMIT = 40;            // Cycles allowed per wait loop
   localparam int LATENCY    = 2;             // Accepting edge to rsp_valid

   logic                clk;
   logic                rst;
   logic                a_req_valid;
   logic                a_req_ready;
   ttl_bus_pkg::op_t    a_op;
   ttl_bus_pkg::addr_t  a_addr;
   ttl_bus_pkg::data_t  a_wdata;
   logic                a_rsp_valid;
   logic                a_rsp_ready;
   ttl_bus_pkg::data_t  a_rsp_data;
   logic                b_req_valid;
   logic                b_req_ready;
   ttl_bus_pkg::op_t    b_op;
   ttl_bus_pkg::addr_t  b_addr;
   ttl_bus_pkg::data_t  b_wdata;
   logic                b_rsp_valid;
   logic                b_rsp_ready;
   ttl_bus_pkg::data_t  b_rsp_data;

   int  errors;
   int  tests;
   int  failed;
   int  seed;                                 // Idle gap generator
   bit  aborted;                              // A wait ran out

   ttl_bus_top #(.REG_COUNT(4)) UUT (
      .clk(clk), .rst(rst),
      .a_req_valid(a_req_valid), .a_req_ready(a_req_ready), .a_op(a_op),
      .a_addr(a_addr), .a_wdata(a_wdata), .a_rsp_valid(a_rsp_valid),
      .a_rsp_ready(a_rsp_ready), .a_rsp_data(a_rsp_data),
      .b_req_valid(b_req_valid), .b_req_ready(b_req_ready), .b_op(b_op),
      .b_addr(b_addr), .b_wdata(b_wdata), .b_rsp_valid(b_rsp_valid),
      .b_rsp_ready(b_rsp_ready), .b_rsp_data(b_rsp_data)
   );

   always #2 clk = ~clk;                      // 4 ns period

   //////////////////////////////
   // Client side helpers
   //////////////////////////////

   // Port 0 is client A, port 1 is client B
   task automatic put_req(input int port, input int op, input int addr, input int wdata);
      if (port == 0) begin
         a_req_valid <= 1'b1;
         a_op        <= ttl_bus_pkg::op_t'(op);
         a_addr      <= ttl_bus_pkg::addr_t'(addr);
         a_wdata     <= ttl_bus_pkg::data_t'(wdata);
      end else begin
         b_req_valid <= 1'b1;
         b_op        <= ttl_bus_pkg::op_t'(op);
         b_addr      <= ttl_bus_pkg::addr_t'(addr);
         b_wdata     <= ttl_bus_pkg::data_t'(wdata);
      end
   endtask

   task automatic drop_req(input int port);
      if (port == 0) a_req_valid <= 1'b0;
      else b_req_valid <= 1'b0;
   endtask

   task automatic set_rsp_ready(input int port, input logic val);
      if (port == 0) a_rsp_ready <= val;
      else b_rsp_ready <= val;
   endtask

   function automatic void sample_port(input int port, output logic valid,
                                       output ttl_bus_pkg::data_t data,
                                       output logic other_ready);
      valid       = (port == 0) ? a_rsp_valid : b_rsp_valid;
      data        = (port == 0) ? a_rsp_data : b_rsp_data;
      other_ready = (port == 0) ? b_req_ready : a_req_ready;  // Must stay low in flight
   endfunction

   // Called on a falling edge, returns -1 on timeout
   task automatic wait_grant(input int want, output int got);
      int cnt;
      cnt = 0;
      got = -1;
      while (got < 0 && !aborted) begin
         if (a_req_ready) got = 0;
         else if (b_req_ready) got = 1;
         else if (cnt >= WAIT_LIMIT) begin
            $display("Timeout at %0t: no client was granted the bus", $time);
            errors++;
            aborted = 1'b1;
         end else begin
            cnt++;
            @(negedge clk);
         end
      end
      if (got >= 0) begin
         assert (got == want && !(a_req_ready && b_req_ready)) else begin
            $display("Mismatch at %0t: grant to port %0d, expected port %0d", $time, got, want);
            errors++;
         end
      end
   endtask

   // Accept, latency, back-pressure hold and transfer
   task automatic take_rsp(input int port, input int exp, input int stall);
      int                  lat;
      logic                valid;
      logic                other_ready;
      ttl_bus_pkg::data_t  data;
      ttl_bus_pkg::data_t  held;
      lat   = 0;
      valid = 1'b0;
      @(posedge clk);                         // Accepting edge
      drop_req(port);
      while (!valid && !aborted) begin
         @(negedge clk);
         sample_port(port, valid, data, other_ready);
         assert (!other_ready) else begin
            $display("Mismatch at %0t: second grant while port %0d busy", $time, port);
            errors++;
         end
         if (!valid) lat++;
         if (lat > WAIT_LIMIT) begin
            $display("Timeout at %0t: port %0d never saw rsp_valid", $time, port);
            errors++;
            aborted = 1'b1;
         end
      end
      if (aborted) return;
      assert (lat == LATENCY) else begin
         $display("Mismatch at %0t: latency %0d, expected %0d", $time, lat, LATENCY);
         errors++;
      end
      assert (data == ttl_bus_pkg::data_t'(exp)) else begin
         $display("Mismatch at %0t: port %0d rsp_data %02h, expected %02h",
                  $time, port, data, exp);
         errors++;
      end
      held = data;
      for (int i = 0; i < stall; i++) begin
         @(negedge clk);
         sample_port(port, valid, data, other_ready);
         assert (valid && data == held && !other_ready) else begin
            $display("Mismatch at %0t: response not held under back-pressure", $time);
            errors++;
         end
      end
      if (stall > 0) begin
         @(posedge clk);
         set_rsp_ready(port, 1'b1);
      end
      @(posedge clk);                         // Response transfer
      @(negedge clk);
      sample_port(port, valid, data, other_ready);
      assert (!valid) else begin
         $display("Mismatch at %0t: rsp_valid still high after transfer", $time);
         errors++;
      end
   endtask

   task automatic report_test(input int tn, input int errs_before);
      if (tn > 0) begin
         tests++;
         if (errors == errs_before) $display("Test %0d passed", tn);
         else begin
            failed++;
            $display("Test %0d failed, %0d errors", tn, errors - errs_before);
         end
      end
   endtask

   //////////////////////////////
   // Stimulus replay
   //////////////////////////////

   initial begin
      int     fd;
      int     n;
      int     got;
      int     gap;
      int     cur_test;
      int     test_errs;
      int     f [12];                         // tn mode port op addr wdata exp ... stall
      string  line;
      clk = 1'b0;
      rst = 1'b0;
      a_req_valid = 1'b0;
      a_op = '0;
      a_addr = '0;
      a_wdata = '0;
      a_rsp_ready = 1'b1;
      b_req_valid = 1'b0;
      b_op = '0;
      b_addr = '0;
      b_wdata = '0;
      b_rsp_ready = 1'b1;
      errors = 0;
      tests = 0;
      failed = 0;
      aborted = 1'b0;
      cur_test = 0;
      test_errs = 0;
      seed = 32'hab36_9ad6;
      fd = $fopen("bench/ttl_bus_stim.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file bench/ttl_bus_stim.txt");
         errors++;
      end
      repeat (4) @(posedge clk);
      rst <= 1'b1;                            // Leave reset
      while (fd != 0 && !aborted && !$feof(fd)) begin
         if ($fgets(line, fd) == 0) line = "";
         n = $sscanf(line, "%d %d %d %h %h %h %h %h %h %h %h %d",
                     f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
         if (n == 12) begin                   // Comments and blanks skipped
            if (f[0] != cur_test) begin
               report_test(cur_test, test_errs);
               cur_test  = f[0];
               test_errs = errors;
            end
            gap = {$random(seed)} % 4;
            repeat (gap) @(posedge clk);
            @(posedge clk);
            put_req(f[2], f[3], f[4], f[5]);
            set_rsp_ready(f[2], f[11] == 0);
            if (f[1] == 1) put_req(1 - f[2], f[7], f[8], f[9]);  // Loser waits
            @(negedge clk);
            wait_grant(f[2], got);
            if (got >= 0) take_rsp(got, f[6], f[11]);
            if (f[1] == 1 && !aborted) begin
               wait_grant(1 - f[2], got);
               if (got >= 0) take_rsp(got, f[10], 0);
            end
         end
      end
      report_test(cur_test, test_errs);
      if (fd != 0) $fclose(fd);
      $display("Tests run %0d, failed %0d, errors %0d", tests, failed, errors);
      if (errors == 0 && tests > 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: bench/ttl_bus_stim.txt
# test mode(0 single,1 both) port(0 A,1 B; first winner) op addr wdata exp
# then op2 addr2 wdata2 exp2 for the other client when mode is 1, then rsp_ready stall cycles
# 1: reset values, first tie goes to A
1 1 0  1 0 00 00  1 1 00 00  0
1 1 0  1 2 00 00  1 3 00 00  0
1 0 0  2 0 00 0A  0 0 00 00  0
# 2: writes, reads, out of range addresses
2 0 0  0 0 5A 5A  0 0 00 00  0
2 0 1  0 1 C3 C3  0 0 00 00  0
2 0 1  1 0 00 5A  0 0 00 00  0
2 0 0  1 1 00 C3  0 0 00 00  0
2 0 0  0 3 81 81  0 0 00 00  0
2 0 1  0 5 77 00  0 0 00 00  0
2 0 0  1 5 00 00  0 0 00 00  0
2 0 1  1 7 00 00  0 0 00 00  0
2 0 0  1 3 00 81  0 0 00 00  0
2 0 1  1 1 00 C3  0 0 00 00  0
# 3: JK set, clear, toggle twice, hold
3 0 0  2 0 0A 05  0 0 00 00  0
3 0 1  2 0 04 06  0 0 00 00  0
3 0 0  2 0 0F 09  0 0 00 00  0
3 0 1  2 0 0F 06  0 0 00 00  0
3 0 0  2 0 F0 06  0 0 00 00  0
3 0 1  2 0 09 09  0 0 00 00  0
3 1 0  2 0 03 05  2 0 05 0A  0
# 4: round robin
4 1 0  0 2 3C 3C  1 2 00 3C  0
4 0 0  1 0 00 5A  0 0 00 00  0
4 1 1  1 2 00 3C  0 0 99 99  0
4 1 1  1 0 00 99  1 3 00 81  0
# 5: back-pressure
5 1 1  1 1 00 C3  1 2 00 3C  5
5 1 1  0 1 E7 E7  1 1 00 E7  3
5 0 0  2 0 00 0A  0 0 00 00  7
# 6: latency, reserved op reads register 0
6 0 1  1 2 00 3C  0 0 00 00  0
6 0 0  0 4 11 00  0 0 00 00  0
6 0 1  3 6 00 99  0 0 00 00  0
6 1 0  1 0 00 99  1 1 00 E7  2

// File: ttl_bus.f
hw/ttl_bus_pkg.sv
hw/octal_reg_bank.sv
hw/jk_flag_pair.sv
hw/bus_target.sv
hw/bus_arbiter.sv
hw/ttl_bus_top.sv
bench/ttl_bus_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module ttl_bus_tb \
   -f ttl_bus.f -o ttl_bus_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/ttl_bus_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
   echo "Simulation passed"
   exit 0
fi
echo "Simulation failed, see $LOG"
exit 1
